// ==== hdl/klDiagPkg.sv ====
// KL10 diagnostic bus definitions
package klDiagPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Diagnostic function codes, octal as in the KL10 maintenance guide
  typedef enum logic [6:0] {
    STOP_CLOCK             = 7'o000,
    START_CLOCK            = 7'o001,
    STEP_CLOCK             = 7'o002,
    COND_STEP              = 7'o004,
    SET_RESET              = 7'o006,
    CLR_RESET              = 7'o007,
    // EBOX run control
    CLR_RUN                = 7'o010,
    SET_RUN                = 7'o011,
    CONTINUE               = 7'o012,
    // Clock board loads
    BURST_CTR_RH           = 7'o042,
    BURST_CTR_LH           = 7'o043,
    CLK_SRC_RATE           = 7'o044,
    SET_EBOX_CLK_DISABLES  = 7'o045,
    RESET_PAR_REGS         = 7'o046,
    MBOXDIS_PARCHK_ERRSTOP = 7'o047,
    // IR decode, channels and memory
    ENABLE_KL              = 7'o067,
    INIT_CHANNELS          = 7'o070,
    WRITE_MBOX             = 7'o071,
    MEM_RESET              = 7'o076
  } tDiagFunction;

  // Plain function strobe or strobe with data on the bus
  typedef enum logic {opFunc, opWrite} tDiagOp;

  // PDP-10 numbering, bit 0 is the MSB
  typedef logic [0:35] tWord36;

  // Outbound EBUS, reads are not modelled
  typedef struct packed {
    logic         diagStrobe;
    tDiagFunction ds;
    logic         driving;
    tWord36       data;
  } tEbusOut;

  // One operation handed to the bus driver
  typedef struct packed {
    logic         start;
    tDiagOp       op;
    tDiagFunction func;
    tWord36       data;
  } tDiagRequest;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe shapes in clock cycles
  localparam int funcStrobeCycles  = 17;
  localparam int writeStrobeCycles = 3;
  localparam int writeDriveCycles  = 4;

  // Front-end bring-up timing
  localparam int crobarCycles     = 20;
  localparam int resetDelayCycles = 10;
  localparam int syncSettleCycles = 11;
  localparam int mboxSyncTries    = 5;
  localparam int haltDelayCycles  = 100;

  // Master reset plus soft reset entries, sync step included
  localparam int resetListLength = 26;

  // Bit 24 sets the MEM RESET flop
  localparam tWord36 memResetData  = 36'o4000;
  localparam tWord36 writeMboxData = 36'o120;

endpackage

// ==== hdl/klLoadPkg.sv ====
// Microcode load file definitions
package klLoadPkg;

  // Token classes out of the ASCII decoder
  typedef enum logic [1:0] {tokType, tokWord, tokEnd} tTokenKind;

  // tokType carries the record letter in value[6:0]
  typedef struct packed {
    logic        valid;
    tTokenKind   kind;
    logic [15:0] value;
  } tLoadToken;

  // Record being parsed, comments and unknown letters are skipped
  typedef enum logic [1:0] {recNone, recCram, recDram, recSkip} tRecordKind;

  ////////////////////////////////////////////////////////////////////////////
  // RAM geometry
  typedef logic [0:85] tCramWord;
  typedef logic [10:0] tCramAddress;
  typedef logic [8:0]  tDramAddress;

  // One control-RAM location
  typedef struct packed {
    logic        write;
    tCramAddress address;
    tCramWord    word;
  } tCramWrite;

  // Even/odd dispatch pair at an even address
  typedef struct packed {
    logic        write;
    tDramAddress address;
    logic [15:0] even;
    logic [15:0] odd;
    logic [15:0] common;
  } tDramWrite;

  // Words per RAM entry and field width of the ASCII encoding
  localparam int cramWordsPerEntry = 6;
  localparam int dramWordsPerPair  = 3;
  localparam int asciiFieldBits    = 6;

endpackage

// ==== hdl/asciiFieldDecoder.sv ====
// ASCII load file field decoder
`timescale 1ns/1ns

module asciiFieldDecoder import klLoadPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      charValid,
  input  logic [6:0] char,
  output tLoadToken token
);

  logic        atLineStart;
  logic        skipNext;
  logic        endPending;
  logic        typePending;
  logic [6:0]  typeChar;
  logic [15:0] fieldAcc;
  logic        isComma;
  logic        isNewline;

  // Field separators
  assign isComma   = char == 7'o054;
  assign isNewline = char == 7'o012;

  function automatic tLoadToken mkToken(tTokenKind kind, logic [15:0] value);
    tLoadToken t;
    t.valid = 1'b1;
    t.kind  = kind;
    t.value = value;
    return t;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      token       <= '0;
      atLineStart <= 1'b1;
      skipNext    <= 1'b0;
      endPending  <= 1'b0;
      typePending <= 1'b0;
      fieldAcc    <= '0;
    end else begin
      token.valid <= 1'b0;

      // End of line goes out before anything of the next line
      if (endPending) begin
        token      <= mkToken(tokEnd, '0);
        endPending <= 1'b0;
      end else if (typePending) begin
        token       <= mkToken(tokType, {9'b0, typeChar});
        typePending <= 1'b0;
      end

      if (charValid) begin
        if (atLineStart) begin
          // Record letter, separator space follows
          atLineStart <= 1'b0;
          skipNext    <= 1'b1;
          if (endPending) begin
            // Slot taken by tokEnd, send it in the space cycle
            typeChar    <= char;
            typePending <= 1'b1;
          end else begin
            token <= mkToken(tokType, {9'b0, char});
          end
        end else if (skipNext) begin
          skipNext <= 1'b0;
        end else if (isComma || isNewline) begin
          // Empty field gives zero
          token    <= mkToken(tokWord, fieldAcc);
          fieldAcc <= '0;
          if (isNewline) begin
            endPending  <= 1'b1;
            atLineStart <= 1'b1;
          end
        end else begin
          // Most significant field first, upper bit of the char dropped
          fieldAcc <= {fieldAcc[15-asciiFieldBits:0], char[asciiFieldBits-1:0]};
        end
      end
    end
  end

endmodule

// ==== hdl/diagBusDriver.sv ====
// EBUS diagnostic strobe driver
`timescale 1ns/1ns

module diagBusDriver import klDiagPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  tDiagRequest request,
  output logic        busy,
  output tEbusOut     ebus
);

  // Counts the cycles of the operation so far
  typedef logic [$clog2(funcStrobeCycles + 2)-1:0] tCount;

  logic   active;
  tDiagOp op;
  tCount  count;
  tCount  strobeLen;
  tCount  activeLen;

  // Shape of the operation in progress
  always_comb begin
    strobeLen = (op == opFunc) ? tCount'(funcStrobeCycles) : tCount'(writeStrobeCycles);
    activeLen = (op == opFunc) ? tCount'(funcStrobeCycles) : tCount'(writeDriveCycles);
  end

  // Includes the quiet cycle after the last active output
  assign busy = active;

  always_ff @(posedge clk) begin
    if (reset) begin
      active          <= 1'b0;
      count           <= '0;
      ebus.diagStrobe <= 1'b0;
      ebus.driving    <= 1'b0;
    end else if (!active) begin
      if (request.start) begin
        // Strobe and data go out together
        active          <= 1'b1;
        count           <= tCount'(1);
        op              <= request.op;
        ebus.diagStrobe <= 1'b1;
        ebus.driving    <= request.op == opWrite;
        ebus.ds         <= request.func;
        ebus.data       <= request.data;
      end
    end else begin
      count           <= count + 1'b1;
      ebus.diagStrobe <= count < strobeLen;
      // Data held one cycle past the strobe on writes
      ebus.driving    <= op == opWrite && count < activeLen;
      if (count == activeLen + 1'b1) begin
        active <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  // Sequencer waits for the bus
  startWhileBusy: assert property (
    @(posedge clk) disable iff (reset) request.start |-> !busy);

  // Bare driving only right after a write strobe ends
  drivingTail: assert property (
    @(posedge clk) disable iff (reset)
    (ebus.driving && !ebus.diagStrobe) |->
      $past(ebus.diagStrobe) && $past(ebus.driving) ##1 !ebus.driving);

endmodule

// ==== hdl/resetSequencer.sv ====
// KL10 bring-up sequencer
`timescale 1ns/1ns

module resetSequencer import klDiagPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        busy,
  input  logic        aChangeComingN,
  input  logic        eboxHalted,
  output tDiagRequest request,
  output logic        crobar,
  output logic        initDone,
  output logic        syncError
);

  typedef enum logic [2:0] {
    stCrobar, stDelay, stList, stSyncWait, stSyncStep,
    stHaltIdle, stHaltWait1, stHaltWait2
  } tSeqState;

  // sync marks the MBOX sync step, its func is the step function
  typedef struct packed {
    logic         sync;
    tDiagOp       op;
    tDiagFunction func;
    tWord36       data;
  } tListEntry;

  typedef logic [$clog2(haltDelayCycles)-1:0] tTimer;
  typedef logic [$clog2(resetListLength)-1:0] tIndex;
  typedef logic [$clog2(mboxSyncTries + 1)-1:0] tSteps;

  tSeqState  state;
  tTimer     timer;
  tIndex     listIndex;
  tSteps     stepCount;
  tListEntry curEntry;
  logic      haltedQ;
  logic      idle;

  ////////////////////////////////////////////////////////////////////////////
  // Master reset then soft reset, ending with the clock running
  function automatic tListEntry listEntry(tIndex idx);
    tListEntry e;
    case (idx)
      0:  e = '{1'b0, opFunc,  CLR_RUN,                '0};
      1:  e = '{1'b0, opWrite, CLK_SRC_RATE,           '0};
      2:  e = '{1'b0, opFunc,  STOP_CLOCK,             '0};
      3:  e = '{1'b0, opFunc,  SET_RESET,              '0};
      4:  e = '{1'b0, opWrite, RESET_PAR_REGS,         '0};
      5:  e = '{1'b0, opWrite, MBOXDIS_PARCHK_ERRSTOP, '0};
      6:  e = '{1'b0, opWrite, BURST_CTR_RH,           '0};
      7:  e = '{1'b0, opWrite, BURST_CTR_LH,           '0};
      8:  e = '{1'b0, opWrite, SET_EBOX_CLK_DISABLES,  '0};
      9:  e = '{1'b0, opFunc,  START_CLOCK,            '0};
      10: e = '{1'b0, opWrite, INIT_CHANNELS,          '0};
      11: e = '{1'b0, opWrite, BURST_CTR_RH,           '0};
      12: e = '{1'b1, opFunc,  STEP_CLOCK,             '0};
      13: e = '{1'b0, opFunc,  COND_STEP,              '0};
      14: e = '{1'b0, opFunc,  CLR_RESET,              '0};
      15: e = '{1'b0, opWrite, ENABLE_KL,              '0};
      16: e = '{1'b0, opWrite, MEM_RESET,              memResetData};
      17: e = '{1'b0, opWrite, MEM_RESET,              '0};
      18: e = '{1'b0, opWrite, WRITE_MBOX,             writeMboxData};
      // Soft reset
      19: e = '{1'b0, opFunc,  SET_RESET,              '0};
      20: e = '{1'b0, opFunc,  START_CLOCK,            '0};
      21: e = '{1'b0, opFunc,  STOP_CLOCK,             '0};
      22: e = '{1'b0, opFunc,  COND_STEP,              '0};
      23: e = '{1'b0, opFunc,  CLR_RESET,              '0};
      // Start in the halt loop
      24: e = '{1'b0, opFunc,  CLR_RUN,                '0};
      25: e = '{1'b0, opFunc,  START_CLOCK,            '0};
      default: e = '0;
    endcase
    return e;
  endfunction

  function automatic tDiagRequest issue(tDiagOp op, tDiagFunction func, tWord36 data);
    tDiagRequest r;
    r.start = 1'b1;
    r.op    = op;
    r.func  = func;
    r.data  = data;
    return r;
  endfunction

  assign curEntry = listEntry(listIndex);

  // Bus free and nothing just launched
  assign idle = !busy && !request.start;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= stCrobar;
      timer         <= '0;
      listIndex     <= '0;
      stepCount     <= '0;
      haltedQ       <= 1'b0;
      crobar        <= 1'b1;
      initDone      <= 1'b0;
      syncError     <= 1'b0;
      request.start <= 1'b0;
    end else begin
      request.start <= 1'b0;
      haltedQ       <= eboxHalted;
      case (state)
        stCrobar: begin
          if (timer == tTimer'(crobarCycles - 1)) begin
            crobar <= 1'b0;
            timer  <= '0;
            state  <= stDelay;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        stDelay: begin
          if (timer == tTimer'(resetDelayCycles - 1)) begin
            timer <= '0;
            state <= stList;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        stList: begin
          if (idle && curEntry.sync) begin
            timer     <= '0;
            stepCount <= '0;
            state     <= stSyncWait;
          end else if (idle) begin
            request   <= issue(curEntry.op, curEntry.func, curEntry.data);
            listIndex <= listIndex + 1'b1;
            if (listIndex == tIndex'(resetListLength - 1)) begin
              state <= stHaltIdle;
            end
          end
        end
        // Let the MBOX settle after the last bus operation
        stSyncWait: begin
          if (!idle) begin
            timer <= '0;
          end else if (timer == tTimer'(syncSettleCycles - 1)) begin
            state <= stSyncStep;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        stSyncStep: begin
          timer <= '0;
          if (aChangeComingN) begin
            listIndex <= listIndex + 1'b1;
            state     <= stList;
          end else if (stepCount == tSteps'(mboxSyncTries)) begin
            // Give up, carry on with the list
            syncError <= 1'b1;
            listIndex <= listIndex + 1'b1;
            state     <= stList;
          end else begin
            request   <= issue(curEntry.op, curEntry.func, curEntry.data);
            stepCount <= stepCount + 1'b1;
            state     <= stSyncWait;
          end
        end
        stHaltIdle: begin
          // Last entry must finish before init is done
          if (!initDone) begin
            initDone <= idle;
          end else if (eboxHalted && !haltedQ) begin
            timer <= '0;
            state <= stHaltWait1;
          end
        end
        stHaltWait1: begin
          if (timer != tTimer'(haltDelayCycles - 1)) begin
            timer <= timer + 1'b1;
          end else if (idle) begin
            request <= issue(opFunc, SET_RUN, '0);
            timer   <= '0;
            state   <= stHaltWait2;
          end
        end
        stHaltWait2: begin
          if (!idle) begin
            timer <= '0;
          end else if (timer == tTimer'(haltDelayCycles - 1)) begin
            // CONTINUE button
            request <= issue(opFunc, CONTINUE, '0);
            state   <= stHaltIdle;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= stCrobar;
      endcase
    end
  end

  // One launch per operation
  startPulse: assert property (
    @(posedge clk) disable iff (reset) request.start |=> !request.start);

endmodule

// ==== hdl/ramLoader.sv ====
// Microcode record loader
`timescale 1ns/1ns

module ramLoader import klLoadPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  tLoadToken token,
  output tCramWrite cramWr,
  output tDramWrite dramWr,
  output logic      loadError
);

  // Position inside a record line
  typedef enum logic [1:0] {phWc, phAddr, phData} tPhase;

  tRecordKind  recKind;
  tPhase       phase;
  logic [15:0] dataLeft;
  logic [15:0] sum;
  logic [2:0]  slot;
  tCramAddress cramAddr;
  tDramAddress dramAddr;
  tCramWord    cramBuf;
  logic [15:0] evenBuf;
  logic [15:0] oddBuf;
  logic        inRecord;
  logic        isWord;
  logic        isData;

  always_comb begin
    inRecord = recKind == recCram || recKind == recDram;
    isWord   = token.valid && token.kind == tokWord && inRecord;
    // After WC words the next one is the checksum
    isData   = isWord && phase == phData && dataLeft != '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      recKind      <= recNone;
      phase        <= phWc;
      dataLeft     <= '0;
      sum          <= '0;
      slot         <= '0;
      cramWr.write <= 1'b0;
      dramWr.write <= 1'b0;
      loadError    <= 1'b0;
    end else begin
      cramWr.write <= 1'b0;
      dramWr.write <= 1'b0;
      // Negated checksum brings the line total to zero
      loadError    <= token.valid && token.kind == tokEnd && inRecord && sum != '0;

      if (token.valid && token.kind == tokType) begin
        case (token.value[7:0])
          "C":     recKind <= recCram;
          "D":     recKind <= recDram;
          default: recKind <= recSkip;
        endcase
        phase <= phWc;
        sum   <= '0;
        slot  <= '0;
      end

      if (token.valid && token.kind == tokEnd) begin
        recKind <= recNone;
      end

      if (isWord) begin
        sum <= sum + token.value;
        case (phase)
          phWc: begin
            dataLeft <= token.value;
            phase    <= phAddr;
          end
          phAddr: begin
            cramAddr <= tCramAddress'(token.value);
            dramAddr <= {token.value[8:1], 1'b0};
            phase    <= phData;
          end
          default: begin
            if (dataLeft != '0) begin
              dataLeft <= dataLeft - 1'b1;
            end
          end
        endcase
      end

      ////////////////////////////////////////////////////////////////////////
      // CRAM, six words per location
      if (isData && recKind == recCram) begin
        slot <= (slot == 3'(cramWordsPerEntry - 1)) ? '0 : slot + 3'd1;
        case (slot)
          3'd0: cramBuf[64:79] <= token.value;
          3'd1: cramBuf[48:63] <= token.value;
          3'd2: cramBuf[32:47] <= token.value;
          3'd3: cramBuf[16:31] <= token.value;
          3'd4: cramBuf[0:15]  <= token.value;
          default: begin
            // Low six bits are CALL and DISP
            cramWr.write   <= 1'b1;
            cramWr.address <= cramAddr;
            cramWr.word    <= {cramBuf[0:79], token.value[5:0]};
            cramAddr       <= cramAddr + 1'b1;
          end
        endcase
      end

      // DRAM, even/odd/common per pair
      if (isData && recKind == recDram) begin
        slot <= (slot == 3'(dramWordsPerPair - 1)) ? '0 : slot + 3'd1;
        case (slot)
          3'd0: evenBuf <= token.value;
          3'd1: oddBuf  <= token.value;
          default: begin
            dramWr.write   <= 1'b1;
            dramWr.address <= dramAddr;
            dramWr.even    <= evenBuf;
            dramWr.odd     <= oddBuf;
            dramWr.common  <= token.value;
            dramAddr       <= dramAddr + 9'd2;
          end
        endcase
      end
    end
  end

  // One RAM port at a time
  oneWrite: assert property (
    @(posedge clk) disable iff (reset) !(cramWr.write && dramWr.write));

endmodule

// ==== hdl/frontEnd.sv ====
// KL10 front end top level
`timescale 1ns/1ns

module frontEnd import klDiagPkg::*, klLoadPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       aChangeComingN,
  input  logic       eboxHalted,
  input  logic       charValid,
  input  logic [6:0] char,
  output tEbusOut    ebus,
  output logic       crobar,
  output logic       initDone,
  output logic       syncError,
  output tCramWrite  cramWr,
  output tDramWrite  dramWr,
  output logic       loadError
);

  tDiagRequest request;
  logic        busy;
  tLoadToken   token;

  ////////////////////////////////////////////////////////////////////////////
  // Bring-up path
  resetSequencer sequencer (
    .clk            (clk),
    .reset          (reset),
    .busy           (busy),
    .aChangeComingN (aChangeComingN),
    .eboxHalted     (eboxHalted),
    .request        (request),
    .crobar         (crobar),
    .initDone       (initDone),
    .syncError      (syncError)
  );

  diagBusDriver busDriver (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .busy    (busy),
    .ebus    (ebus)
  );

  // Microcode load path
  asciiFieldDecoder decoder (
    .clk       (clk),
    .reset     (reset),
    .charValid (charValid),
    .char      (char),
    .token     (token)
  );

  ramLoader loader (
    .clk       (clk),
    .reset     (reset),
    .token     (token),
    .cramWr    (cramWr),
    .dramWr    (dramWr),
    .loadError (loadError)
  );

endmodule

// ==== tests/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module clockGen (
  input  logic restart,
  output logic clk,
  output logic reset
);

  // Reset cycles still to go
  int resetLeft;

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    resetLeft = 5;
  end

  // 4 ns period
  always #2 clk = ~clk;

  // Reset held for five rising edges, at start and on each restart
  always @(posedge clk) begin
    if (restart) begin
      reset     <= 1'b1;
      resetLeft <= 5;
    end else if (resetLeft > 1) begin
      resetLeft <= resetLeft - 1;
    end else begin
      reset     <= 1'b0;
      resetLeft <= 0;
    end
  end

endmodule

// ==== tests/frontEndTb.sv ====
// KL10 front end testbench
`timescale 1ns/1ns

module frontEndTb import klDiagPkg::*, klLoadPkg::*; ();

  // Bring-up timing as the front end should show it
  localparam int crobarHold  = 20;
  localparam int quietAfter  = 10;
  localparam int funcLen     = 17;
  localparam int writeLen    = 3;
  localparam int writeDrive  = 4;
  localparam int haltDelay   = 100;
  localparam int syncIndex   = 12;
  localparam int opTimeout   = 64;
  localparam int haltTimeout = 300;

  // One entry of the expected EBUS operation list
  typedef struct packed {
    tDiagFunction func;
    logic         isWrite;
    tWord36       data;
  } tExpectedOp;

  logic       clk;
  logic       reset;
  logic       restart;
  logic       aChangeComingN;
  logic       eboxHalted;
  logic       charValid;
  logic [6:0] loadChar;
  tEbusOut    ebus;
  logic       crobar;
  logic       initDone;
  logic       syncError;
  tCramWrite  cramWr;
  tDramWrite  dramWr;
  logic       loadError;

  int         seed;
  int         syncSteps;
  int         loadErrors;
  tExpectedOp expOps[$];
  tCramWrite  expCram[$];
  tDramWrite  expDram[$];
  tCramWrite  nextCram;
  tDramWrite  nextDram;

  clockGen clocks (
    .restart (restart),
    .clk     (clk),
    .reset   (reset)
  );

  frontEnd dut (
    .clk            (clk),
    .reset          (reset),
    .aChangeComingN (aChangeComingN),
    .eboxHalted     (eboxHalted),
    .charValid      (charValid),
    .char           (loadChar),
    .ebus           (ebus),
    .crobar         (crobar),
    .initDone       (initDone),
    .syncError      (syncError),
    .cramWr         (cramWr),
    .dramWr         (dramWr),
    .loadError      (loadError)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting

  task automatic failNow();
    $display("Test failures found");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic stopWithFailure(input string reason);
    $display("Error at %0t ns: %s", $time, reason);
    failNow();
  endtask

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      failNow();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // EBUS model

  task automatic addOp(input tDiagFunction func, input bit isWrite, input tWord36 data);
    tExpectedOp e;
    e.func    = func;
    e.isWrite = isWrite;
    e.data    = data;
    expOps.push_back(e);
  endtask

  // Master reset then soft reset without the sync step
  task automatic buildOpList();
    addOp(CLR_RUN, 0, '0);
    addOp(CLK_SRC_RATE, 1, '0);
    addOp(STOP_CLOCK, 0, '0);
    addOp(SET_RESET, 0, '0);
    addOp(RESET_PAR_REGS, 1, '0);
    addOp(MBOXDIS_PARCHK_ERRSTOP, 1, '0);
    addOp(BURST_CTR_RH, 1, '0);
    addOp(BURST_CTR_LH, 1, '0);
    addOp(SET_EBOX_CLK_DISABLES, 1, '0);
    addOp(START_CLOCK, 0, '0);
    addOp(INIT_CHANNELS, 1, '0);
    addOp(BURST_CTR_RH, 1, '0);
    addOp(COND_STEP, 0, '0);
    addOp(CLR_RESET, 0, '0);
    addOp(ENABLE_KL, 1, '0);
    addOp(MEM_RESET, 1, 36'o4000);
    addOp(MEM_RESET, 1, '0);
    addOp(WRITE_MBOX, 1, 36'o120);
    addOp(SET_RESET, 0, '0);
    addOp(START_CLOCK, 0, '0);
    addOp(STOP_CLOCK, 0, '0);
    addOp(COND_STEP, 0, '0);
    addOp(CLR_RESET, 0, '0);
    addOp(CLR_RUN, 0, '0);
    addOp(START_CLOCK, 0, '0);
  endtask

  // Waits for the next strobe and measures it until the bus is quiet
  task automatic checkOp(input tExpectedOp e, input int timeout, output int waited);
    int strobeLen;
    int driveLen;
    waited = 0;
    @(negedge clk);
    while (!ebus.diagStrobe) begin
      if (waited == timeout) stopWithFailure("no diagnostic strobe before the timeout");
      waited++;
      @(negedge clk);
    end
    checkValue("ebus.ds", ebus.ds, e.func);
    strobeLen = 0;
    driveLen  = 0;
    while (ebus.diagStrobe || ebus.driving) begin
      if (ebus.diagStrobe) strobeLen++;
      if (ebus.driving) begin
        driveLen++;
        checkValue("ebus.data", ebus.data, e.data);
      end
      if (strobeLen + driveLen > 2 * timeout) stopWithFailure("diagnostic strobe never ends");
      @(negedge clk);
    end
    checkValue("diagStrobe cycles", strobeLen, e.isWrite ? writeLen : funcLen);
    checkValue("driving cycles", driveLen, e.isWrite ? writeDrive : 0);
  endtask

  task automatic waitResetRelease();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 20) stopWithFailure("reset never released");
    end while (reset);
  endtask

  // Crowbar and reset list with MBOX sync up to initDone
  task automatic runBringUp(input bit doRestart, input int steps, input bit holdLow);
    tExpectedOp stepOp;
    int         count;
    int         waited;
    stepOp.func    = STEP_CLOCK;
    stepOp.isWrite = 1'b0;
    stepOp.data    = '0;
    // A CHANGE COMING stays asserted until the wanted steps are seen
    aChangeComingN = !(holdLow || steps > 0);
    if (doRestart) begin
      restart = 1'b1;
      @(negedge clk);
      restart = 1'b0;
    end
    waitResetRelease();
    checkValue("crobar", crobar, 1);
    count = 0;
    while (crobar) begin
      count++;
      if (count > crobarHold + 5) stopWithFailure("crobar never released");
      @(negedge clk);
    end
    checkValue("crobar high cycles", count, crobarHold);
    for (int i = 0; i < expOps.size(); i++) begin
      if (i == syncIndex) begin
        for (int s = 0; s < steps; s++) begin
          checkOp(stepOp, opTimeout, waited);
          if (!holdLow && s == steps - 1) aChangeComingN = 1'b1;
        end
      end
      checkOp(expOps[i], opTimeout, waited);
      if (i == 0 && waited < quietAfter) begin
        stopWithFailure("diagStrobe rose too soon after crobar release");
      end
      if (i == expOps.size() - 1) checkValue("initDone", initDone, 0);
    end
    checkValue("syncError", syncError, holdLow);
    count = 0;
    while (!initDone) begin
      count++;
      if (count > 8) stopWithFailure("initDone did not rise after the last entry");
      @(negedge clk);
    end
  endtask

  // SET_RUN then CONTINUE with nothing in between or after
  task automatic checkHaltResponse();
    tExpectedOp e;
    int         waited;
    e.isWrite  = 1'b0;
    e.data     = '0;
    eboxHalted = 1'b1;
    e.func     = SET_RUN;
    checkOp(e, haltTimeout, waited);
    if (waited < haltDelay) stopWithFailure("SET_RUN came before the halt delay");
    eboxHalted = 1'b0;
    e.func     = CONTINUE;
    checkOp(e, haltTimeout, waited);
    if (waited < haltDelay) stopWithFailure("CONTINUE came before the halt delay");
    for (int i = 0; i < 150; i++) begin
      @(negedge clk);
      if (ebus.diagStrobe) stopWithFailure("extra operation after CONTINUE");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Load file encoder

  // Fields below octal 75 are moved up into the letters
  function automatic byte encodeField(input logic [5:0] field);
    return (field < 6'o75) ? {2'b00, field} + 8'o100 : {2'b00, field};
  endfunction

  task automatic sendChar(input byte c);
    charValid = 1'b1;
    loadChar  = c[6:0];
    @(negedge clk);
  endtask

  task automatic sendText(input string s);
    for (int i = 0; i < s.len(); i++) begin
      sendChar(s[i]);
    end
  endtask

  // Most significant field first with 4 bits in the top field
  task automatic sendWord(input logic [15:0] value);
    sendChar(encodeField({2'b00, value[15:12]}));
    sendChar(encodeField(value[11:6]));
    sendChar(encodeField(value[5:0]));
  endtask

  task automatic sendRecord(input byte kind, input int entries, input logic [15:0] address,
                            input bit badSum);
    int          perEntry;
    logic [15:0] words[$];
    logic [15:0] entryWords[6];
    logic [15:0] sum;
    tCramWrite   cw;
    tDramWrite   dw;
    perEntry = (kind == "C") ? 6 : 3;
    words.push_back(16'(entries * perEntry));
    words.push_back(address);
    for (int e = 0; e < entries; e++) begin
      for (int w = 0; w < perEntry; w++) begin
        entryWords[w] = 16'($random(seed));
        words.push_back(entryWords[w]);
      end
      if (kind == "C") begin
        cw.write   = 1'b1;
        cw.address = address[10:0] + 11'(e);
        cw.word    = {entryWords[4], entryWords[3], entryWords[2], entryWords[1],
                      entryWords[0], entryWords[5][5:0]};
        expCram.push_back(cw);
      end else begin
        dw.write   = 1'b1;
        dw.address = {address[8:1], 1'b0} + 9'(2 * e);
        dw.even    = entryWords[0];
        dw.odd     = entryWords[1];
        dw.common  = entryWords[2];
        expDram.push_back(dw);
      end
    end
    // Negated sum with bit 0 flipped on the bad record
    sum = '0;
    foreach (words[i]) sum += words[i];
    words.push_back(badSum ? (-sum) ^ 16'h0001 : -sum);
    sendChar(kind);
    sendChar(" ");
    foreach (words[i]) begin
      sendWord(words[i]);
      sendChar((i == words.size() - 1) ? 8'o012 : ",");
    end
  endtask

  // Lines go back to back so records overlap in the pipeline
  task automatic runLoader();
    int entries;
    loadErrors = 0;
    sendText("; KL10 MICROCODE, RANDOM LOAD\n");
    for (int r = 0; r < 8; r++) begin
      entries = 1 + {$random(seed)} % 3;
      sendRecord((r % 2 == 0) ? "C" : "D", entries, 16'($random(seed)), r == 5);
    end
    // End record writes nothing
    sendRecord("C", 0, 16'h0000, 1'b0);
    charValid = 1'b0;
    repeat (10) @(negedge clk);
    checkValue("loadError pulses", loadErrors, 1);
    checkValue("missing control-RAM writes", expCram.size(), 0);
    checkValue("missing dispatch-RAM writes", expDram.size(), 0);
  endtask

  // RAM writes in order against the encoder model
  always @(negedge clk) begin
    if (!reset && cramWr.write) begin
      if (expCram.size() == 0) stopWithFailure("unexpected control-RAM write");
      nextCram = expCram.pop_front();
      checkValue("cramWr.address", cramWr.address, nextCram.address);
      checkValue("cramWr.word", cramWr.word, nextCram.word);
    end
    if (!reset && dramWr.write) begin
      if (expDram.size() == 0) stopWithFailure("unexpected dispatch-RAM write");
      nextDram = expDram.pop_front();
      checkValue("dramWr.address", dramWr.address, nextDram.address);
      checkValue("dramWr.even", dramWr.even, nextDram.even);
      checkValue("dramWr.odd", dramWr.odd, nextDram.odd);
      checkValue("dramWr.common", dramWr.common, nextDram.common);
    end
    if (!reset && loadError) loadErrors++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed           = 72;
    restart        = 1'b0;
    aChangeComingN = 1'b1;
    eboxHalted     = 1'b0;
    charValid      = 1'b0;
    loadChar       = '0;
    loadErrors     = 0;
    buildOpList();

    // Clean bring-up, halt response and microcode load
    runBringUp(1'b0, 0, 1'b0);
    checkHaltResponse();
    runLoader();

    // MBOX settles after a random number of steps
    syncSteps = {$random(seed)} % 5;
    runBringUp(1'b1, syncSteps, 1'b0);

    // MBOX never settles
    runBringUp(1'b1, 5, 1'b1);

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/klDiagPkg.sv
hdl/klLoadPkg.sv
hdl/asciiFieldDecoder.sv
hdl/diagBusDriver.sv
hdl/resetSequencer.sv
hdl/ramLoader.sv
hdl/frontEnd.sv
tests/clockGen.sv
tests/frontEndTb.sv

// ==== Bender.yml ====
package:
  name: klFrontEnd

sources:
  - hdl/klDiagPkg.sv
  - hdl/klLoadPkg.sv
  - hdl/asciiFieldDecoder.sv
  - hdl/diagBusDriver.sv
  - hdl/resetSequencer.sv
  - hdl/ramLoader.sv
  - hdl/frontEnd.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/frontEndTb.sv
